// File: fetch_stage.f
source/fetch_pkg.sv
source/bpred_pkg.sv
source/pc_select.sv
source/branch_predictor.sv
source/fetch_stage.sv
verif/fetch_stage_sva.sv
verif/fetch_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the fetch stage testbench with Verilator and run it.
# The run passes only if the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fetch_stage_tb -f fetch_stage.f -o fetch_stage_sim \
    && ./obj_dir/fetch_stage_sim | tee /dev/stderr | grep -q "All checks passed" \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }

// File: source/bpred_pkg.sv
// Branch target buffer definitions.
// Counter type and the encoding of the 2-bit saturating counter.

`default_nettype none

package bpred_pkg;

    // 2-bit saturating direction counter
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_MIN = 2'd0;
    localparam ctr_t CTR_MAX = 2'd3;

    // counters at or above this value predict taken
    localparam ctr_t CTR_WEAK_TAKEN = 2'd2;

    // value written on allocation of a new entry
    localparam ctr_t CTR_INIT_TAKEN = 2'd2;

endpackage

`default_nettype wire

// File: source/branch_predictor.sv
// Direct-mapped branch target buffer with 2-bit saturating counters.
// Lookup on the fetch pc is combinational, training from the execute
// stage is written at the clock edge.

`default_nettype none

module branch_predictor #(
    parameter int BTB_ENTRIES = 16
) (
    input  wire logic             clk_i,
    input  wire logic             rstn_i,
    input  wire fetch_pkg::addr_t pc_i,
    input  wire logic             upd_valid_i,
    input  wire fetch_pkg::addr_t upd_pc_i,
    input  wire logic             upd_taken_i,
    input  wire fetch_pkg::addr_t upd_target_i,
    output logic                  pred_hit_o,
    output logic                  pred_taken_o,
    output fetch_pkg::addr_t      pred_target_o
);
    import bpred_pkg::*;

    localparam int IDX_BITS = $clog2(BTB_ENTRIES);
    localparam int TAG_BITS = 32 - 2 - IDX_BITS;

    typedef logic [IDX_BITS-1:0] idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    // entry storage, only the valid bits are reset
    logic             valid_q  [BTB_ENTRIES];
    tag_t             tag_q    [BTB_ENTRIES];
    fetch_pkg::addr_t target_q [BTB_ENTRIES];
    ctr_t             ctr_q    [BTB_ENTRIES];

    idx_t rd_idx;
    tag_t rd_tag;
    idx_t upd_idx;
    tag_t upd_tag;
    logic upd_hit;

    // index from bit 2 upward, tag is what remains above it
    assign rd_idx  = pc_i[IDX_BITS+1:2];
    assign rd_tag  = pc_i[31:IDX_BITS+2];
    assign upd_idx = upd_pc_i[IDX_BITS+1:2];
    assign upd_tag = upd_pc_i[31:IDX_BITS+2];

    // lookup
    assign pred_hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign pred_taken_o  = pred_hit_o && (ctr_q[rd_idx] >= CTR_WEAK_TAKEN);
    assign pred_target_o = target_q[rd_idx];

    assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    // allocate on a taken miss
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_valid_i && upd_taken_i && !upd_hit) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // training of tag, target and counter
    always_ff @(posedge clk_i) begin
        if (upd_valid_i) begin
            if (upd_taken_i) begin
                target_q[upd_idx] <= upd_target_i;
                if (upd_hit) begin
                    if (ctr_q[upd_idx] != CTR_MAX) begin
                        ctr_q[upd_idx] <= ctr_q[upd_idx] + 2'd1;
                    end
                end else begin
                    tag_q[upd_idx] <= upd_tag;
                    ctr_q[upd_idx] <= CTR_INIT_TAKEN;
                end
            end else if (upd_hit && (ctr_q[upd_idx] != CTR_MIN)) begin
                // not taken and missing leaves the table alone
                ctr_q[upd_idx] <= ctr_q[upd_idx] - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_pkg.sv
// Fetch-side definitions shared by the PC selection logic and the top level.
// Holds the address type, the next-PC select encoding and the
// instruction fetch exception causes.

`default_nettype none

package fetch_pkg;

    // physical instruction address, no translation in this stage
    typedef logic [31:0] addr_t;

    // size of one instruction in bytes
    localparam addr_t INSTR_BYTES = 32'd4;

    // next pc source, driven by the control unit
    typedef enum logic [1:0] {
        SEL_KEEP      = 2'd0,
        SEL_BP_OR_PC4 = 2'd1,
        SEL_JUMP      = 2'd2,
        SEL_DEBUG     = 2'd3
    } next_pc_sel_t;

    // exception cause as carried in the fetch packet
    typedef logic [3:0] xcpt_cause_t;

    // instruction address misaligned
    localparam xcpt_cause_t CAUSE_MISALIGNED = 4'd0;

    // instruction access fault, fetch outside the mapped window
    localparam xcpt_cause_t CAUSE_ACCESS_FAULT = 4'd1;

endpackage

`default_nettype wire

// File: source/fetch_stage.sv
// First instruction fetch stage.
// Joins PC selection and the branch predictor, builds the fetch packet
// for the second stage and the request toward the instruction cache.

`default_nettype none

module fetch_stage #(
    parameter fetch_pkg::addr_t MEM_BASE    = 32'h8000_0000,
    parameter logic [31:0]      MEM_SIZE    = 32'h0001_0000,
    parameter int               BTB_ENTRIES = 16
) (
    input  wire logic                    clk_i,
    input  wire logic                    rstn_i,
    input  wire fetch_pkg::addr_t        reset_addr_i,
    input  wire fetch_pkg::next_pc_sel_t next_pc_sel_i,
    input  wire fetch_pkg::addr_t        pc_jump_i,
    input  wire logic                    fetch_ready_i,
    input  wire logic                    invalidate_icache_i,
    input  wire logic                    retry_fetch_i,
    input  wire logic                    upd_valid_i,
    input  wire fetch_pkg::addr_t        upd_pc_i,
    input  wire logic                    upd_taken_i,
    input  wire fetch_pkg::addr_t        upd_target_i,
    output logic                         fetch_valid_o,
    output fetch_pkg::addr_t             fetch_pc_o,
    output logic                         fetch_xcpt_valid_o,
    output fetch_pkg::xcpt_cause_t       fetch_xcpt_cause_o,
    output logic                         bpred_hit_o,
    output logic                         bpred_taken_o,
    output fetch_pkg::addr_t             bpred_target_o,
    output logic                         icache_req_valid_o,
    output fetch_pkg::addr_t             icache_req_addr_o,
    output logic                         icache_inval_o
);
    import fetch_pkg::*;

    addr_t pc;
    addr_t pred_target;
    logic  pred_hit;
    logic  pred_taken;

    pc_select #(
        .MEM_BASE (MEM_BASE),
        .MEM_SIZE (MEM_SIZE)
    ) pc_select_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .reset_addr_i  (reset_addr_i),
        .next_pc_sel_i (next_pc_sel_i),
        .pc_jump_i     (pc_jump_i),
        .fetch_ready_i (fetch_ready_i),
        .pred_hit_i    (pred_hit),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .pc_o          (pc),
        .xcpt_valid_o  (fetch_xcpt_valid_o),
        .xcpt_cause_o  (fetch_xcpt_cause_o),
        .req_valid_o   (icache_req_valid_o)
    );

    branch_predictor #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) branch_predictor_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .pc_i          (pc),
        .upd_valid_i   (upd_valid_i),
        .upd_pc_i      (upd_pc_i),
        .upd_taken_i   (upd_taken_i),
        .upd_target_i  (upd_target_i),
        .pred_hit_o    (pred_hit),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target)
    );

    // a packet is offered every cycle out of reset, faulting ones included
    assign fetch_valid_o = rstn_i;
    assign fetch_pc_o    = pc;

    // prediction travels with the packet
    assign bpred_hit_o    = pred_hit;
    assign bpred_taken_o  = pred_taken;
    assign bpred_target_o = pred_target;

    assign icache_req_addr_o = pc;
    assign icache_inval_o    = invalidate_icache_i | retry_fetch_i;

endmodule

`default_nettype wire

// File: source/pc_select.sv
// PC selection for the first fetch stage.
// Holds the program counter, picks the next one from keep, prediction
// or pc + 4, jump and debug redirect, and checks the fetch address
// for misalignment and for accesses outside the mapped window.

`default_nettype none

module pc_select #(
    parameter fetch_pkg::addr_t MEM_BASE = 32'h8000_0000,
    parameter logic [31:0]      MEM_SIZE = 32'h0001_0000
) (
    input  wire logic                   clk_i,
    input  wire logic                   rstn_i,
    input  wire fetch_pkg::addr_t       reset_addr_i,
    input  wire fetch_pkg::next_pc_sel_t next_pc_sel_i,
    input  wire fetch_pkg::addr_t       pc_jump_i,
    input  wire logic                   fetch_ready_i,
    input  wire logic                   pred_hit_i,
    input  wire logic                   pred_taken_i,
    input  wire fetch_pkg::addr_t       pred_target_i,
    output fetch_pkg::addr_t            pc_o,
    output logic                        xcpt_valid_o,
    output fetch_pkg::xcpt_cause_t      xcpt_cause_o,
    output logic                        req_valid_o
);
    import fetch_pkg::*;

    // end of the mapped window, one bit wider so base + size cannot wrap
    localparam logic [32:0] MEM_END = {1'b0, MEM_BASE} + {1'b0, MEM_SIZE};

    addr_t pc_q;
    addr_t next_pc;
    logic  misaligned;
    logic  access_fault;

    // next pc choice
    always_comb begin
        case (next_pc_sel_i)
            SEL_JUMP,
            SEL_DEBUG: begin
                // redirects win over back-pressure
                next_pc = pc_jump_i;
            end
            SEL_BP_OR_PC4: begin
                if (!fetch_ready_i) begin
                    next_pc = pc_q;
                end else if (pred_hit_i && pred_taken_i) begin
                    next_pc = pred_target_i;
                end else begin
                    next_pc = pc_q + INSTR_BYTES;
                end
            end
            default: begin
                next_pc = pc_q;
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= reset_addr_i;
        end else begin
            pc_q <= next_pc;
        end
    end

    // address checks on the current pc
    assign misaligned   = |pc_q[1:0];
    assign access_fault = (pc_q < MEM_BASE) || ({1'b0, pc_q} >= MEM_END);

    // misalignment takes priority over the access fault
    always_comb begin
        if (misaligned) begin
            xcpt_valid_o = 1'b1;
            xcpt_cause_o = CAUSE_MISALIGNED;
        end else if (access_fault) begin
            xcpt_valid_o = 1'b1;
            xcpt_cause_o = CAUSE_ACCESS_FAULT;
        end else begin
            xcpt_valid_o = 1'b0;
            xcpt_cause_o = CAUSE_MISALIGNED;
        end
    end

    // no cache access for a faulting fetch
    assign req_valid_o = rstn_i && !xcpt_valid_o;

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: verif/fetch_stage_sva.sv
// Assertions on the fetch stage ports.
// Exceptions block the cache request, the pc holds under SEL_KEEP with
// ready low, and a misaligned pc always reports the misalignment cause.

`default_nettype none

module fetch_stage_sva (
    input wire logic                    clk_i,
    input wire logic                    rstn_i,
    input wire fetch_pkg::next_pc_sel_t next_pc_sel_i,
    input wire logic                    fetch_ready_i,
    input wire fetch_pkg::addr_t        fetch_pc_o,
    input wire logic                    fetch_xcpt_valid_o,
    input wire fetch_pkg::xcpt_cause_t  fetch_xcpt_cause_o,
    input wire logic                    icache_req_valid_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    no_req_on_xcpt: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fetch_xcpt_valid_o |-> !icache_req_valid_o)
        else $error("cache request issued for a faulting fetch");

    pc_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (!fetch_ready_i && next_pc_sel_i == SEL_KEEP) |=> $stable(fetch_pc_o))
        else $error("pc moved while held with ready low");

    // misalignment wins over the access fault
    misaligned_cause: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (|fetch_pc_o[1:0]) |-> (fetch_xcpt_valid_o && fetch_xcpt_cause_o == CAUSE_MISALIGNED))
        else $error("misaligned pc without misalignment cause");

endmodule

bind fetch_stage fetch_stage_sva sva_inst (.*);

`default_nettype wire

// File: verif/fetch_stage_tb.sv
// Testbench for the first instruction fetch stage.
// Directed tests for sequential fetch, back-pressure, redirects,
// fetch exceptions, predictor training and cache invalidation.

`default_nettype none

module fetch_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    localparam addr_t       MEM_BASE    = 32'h8000_0000;
    localparam logic [31:0] MEM_SIZE    = 32'h0001_0000;
    localparam int          BTB_ENTRIES = 16;
    localparam addr_t       RESET_ADDR  = 32'h8000_0000;
    localparam addr_t       BR_PC       = 32'h8000_0100;
    localparam addr_t       BR_TARGET   = 32'h8000_0800;
    // same index as BR_PC, different tag
    localparam addr_t       ALIAS_PC    = BR_PC + 32'(BTB_ENTRIES * 4);

    logic         clk_i;
    logic         rstn_i;
    addr_t        reset_addr_i;
    next_pc_sel_t next_pc_sel_i;
    addr_t        pc_jump_i;
    logic         fetch_ready_i;
    logic         invalidate_icache_i;
    logic         retry_fetch_i;
    logic         upd_valid_i;
    addr_t        upd_pc_i;
    logic         upd_taken_i;
    addr_t        upd_target_i;
    logic         fetch_valid_o;
    addr_t        fetch_pc_o;
    logic         fetch_xcpt_valid_o;
    xcpt_cause_t  fetch_xcpt_cause_o;
    logic         bpred_hit_o;
    logic         bpred_taken_o;
    addr_t        bpred_target_o;
    logic         icache_req_valid_o;
    addr_t        icache_req_addr_o;
    logic         icache_inval_o;

    logic [31:0]  lcg_state;
    addr_t        exp_pc;

    fetch_stage #(
        .MEM_BASE    (MEM_BASE),
        .MEM_SIZE    (MEM_SIZE),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) dut (.*);

    always #50 clk_i = ~clk_i;

    task automatic stop_run(input string why);
        $display("Checks failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run("address mismatch");
        end
    endtask

    task automatic check_cause(input xcpt_cause_t got, input xcpt_cause_t exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            stop_run("exception cause mismatch");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run("control bit mismatch");
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // aligned address somewhere in the mapped window
    function automatic addr_t rand_target();
        return MEM_BASE + ((lcg_next() % MEM_SIZE) & 32'hffff_fffc);
    endfunction

    task automatic step();
        @(negedge clk_i);
    endtask

    task automatic apply(input next_pc_sel_t sel, input logic ready, input addr_t jump);
        next_pc_sel_i = sel;
        fetch_ready_i = ready;
        pc_jump_i     = jump;
    endtask

    task automatic wait_valid(input int max_cycles);
        int n;
        n = 0;
        do begin
            step();
            n++;
            if (n > max_cycles) begin
                stop_run("timeout: fetch_valid_o never rose after reset");
            end
        end while (!fetch_valid_o);
    endtask

    task automatic check_fetch(input addr_t pc, input logic req);
        check_bit(fetch_valid_o, 1'b1, "fetch_valid_o");
        check_addr(fetch_pc_o, pc, "fetch_pc_o");
        check_addr(icache_req_addr_o, pc, "icache_req_addr_o");
        check_bit(icache_req_valid_o, req, "icache_req_valid_o");
    endtask

    // redirect lands one cycle later, then the pc is held
    task automatic redirect_to(input next_pc_sel_t sel, input addr_t tgt);
        apply(sel, 1'b1, tgt);
        step();
        exp_pc = tgt;
        apply(SEL_KEEP, 1'b1, 32'h0);
        check_addr(fetch_pc_o, exp_pc, "fetch_pc_o after redirect");
    endtask

    task automatic train(input addr_t pc, input logic taken, input addr_t target);
        upd_valid_i  = 1'b1;
        upd_pc_i     = pc;
        upd_taken_i  = taken;
        upd_target_i = target;
        step();
        upd_valid_i  = 1'b0;
    endtask

    task automatic test_sequential();
        exp_pc = RESET_ADDR;
        check_fetch(exp_pc, 1'b1);
        check_bit(bpred_hit_o, 1'b0, "bpred_hit_o after reset");
        apply(SEL_BP_OR_PC4, 1'b1, 32'h0);
        for (int i = 0; i < 6; i++) begin
            step();
            exp_pc = exp_pc + 32'd4;
            check_fetch(exp_pc, 1'b1);
        end
        apply(SEL_KEEP, 1'b1, 32'h0);
    endtask

    task automatic test_back_pressure();
        addr_t tgt;
        apply(SEL_BP_OR_PC4, 1'b0, 32'h0);
        repeat (4) begin
            step();
            check_fetch(exp_pc, 1'b1);
        end
        // redirect is taken even with ready low
        tgt = rand_target();
        apply(SEL_JUMP, 1'b0, tgt);
        step();
        check_addr(fetch_pc_o, tgt, "fetch_pc_o after jump under back-pressure");
        exp_pc = tgt;
        apply(SEL_KEEP, 1'b1, 32'h0);
    endtask

    task automatic test_redirects();
        redirect_to(SEL_JUMP, rand_target());
        check_fetch(exp_pc, 1'b1);
        redirect_to(SEL_DEBUG, rand_target());
        check_fetch(exp_pc, 1'b1);
        repeat (3) begin
            step();
            check_fetch(exp_pc, 1'b1);
        end
    endtask

    task automatic check_exception(input addr_t tgt, input xcpt_cause_t cause);
        redirect_to(SEL_JUMP, tgt);
        check_bit(fetch_xcpt_valid_o, 1'b1, "fetch_xcpt_valid_o");
        check_cause(fetch_xcpt_cause_o, cause, "fetch_xcpt_cause_o");
        check_fetch(tgt, 1'b0);
    endtask

    task automatic test_exceptions();
        check_exception(MEM_BASE + 32'h102, CAUSE_MISALIGNED);
        check_exception(MEM_BASE - 32'd4, CAUSE_ACCESS_FAULT);
        check_exception(MEM_BASE + MEM_SIZE, CAUSE_ACCESS_FAULT);
        check_exception(MEM_BASE + MEM_SIZE + 32'd1, CAUSE_MISALIGNED);
        redirect_to(SEL_JUMP, MEM_BASE);
        check_bit(fetch_xcpt_valid_o, 1'b0, "fetch_xcpt_valid_o back in window");
    endtask

    task automatic test_predictor();
        train(BR_PC, 1'b1, BR_TARGET);
        redirect_to(SEL_JUMP, BR_PC);
        check_bit(bpred_hit_o, 1'b1, "bpred_hit_o after taken training");
        check_bit(bpred_taken_o, 1'b1, "bpred_taken_o");
        check_addr(bpred_target_o, BR_TARGET, "bpred_target_o");
        apply(SEL_BP_OR_PC4, 1'b1, 32'h0);
        step();
        apply(SEL_KEEP, 1'b1, 32'h0);
        check_addr(fetch_pc_o, BR_TARGET, "fetch_pc_o after taken prediction");
        // two not-taken outcomes bring the counter below the taken threshold
        train(BR_PC, 1'b0, 32'h0);
        train(BR_PC, 1'b0, 32'h0);
        redirect_to(SEL_JUMP, BR_PC);
        check_bit(bpred_hit_o, 1'b1, "bpred_hit_o after not-taken training");
        check_bit(bpred_taken_o, 1'b0, "bpred_taken_o");
        apply(SEL_BP_OR_PC4, 1'b1, 32'h0);
        step();
        apply(SEL_KEEP, 1'b1, 32'h0);
        check_addr(fetch_pc_o, BR_PC + 32'd4, "fetch_pc_o after not-taken prediction");
        redirect_to(SEL_JUMP, ALIAS_PC);
        check_bit(bpred_hit_o, 1'b0, "bpred_hit_o for aliasing tag");
    endtask

    task automatic test_invalidate();
        for (int i = 0; i < 4; i++) begin
            invalidate_icache_i = i[0];
            retry_fetch_i       = i[1];
            step();
            check_bit(icache_inval_o, i[0] | i[1], "icache_inval_o");
        end
        invalidate_icache_i = 1'b0;
        retry_fetch_i       = 1'b0;
    endtask

    initial begin
        clk_i               = 1'b0;
        rstn_i              = 1'b0;
        reset_addr_i        = RESET_ADDR;
        invalidate_icache_i = 1'b0;
        retry_fetch_i       = 1'b0;
        upd_valid_i         = 1'b0;
        upd_pc_i            = 32'h0;
        upd_taken_i         = 1'b0;
        upd_target_i        = 32'h0;
        lcg_state           = 32'hdb1b_9b98;
        exp_pc              = RESET_ADDR;
        apply(SEL_KEEP, 1'b0, 32'h0);
        repeat (3) step();
        // nothing is offered while reset is held
        check_bit(fetch_valid_o, 1'b0, "fetch_valid_o in reset");
        check_bit(icache_req_valid_o, 1'b0, "icache_req_valid_o in reset");
        rstn_i = 1'b1;
        wait_valid(5);
        test_sequential();
        test_back_pressure();
        test_redirects();
        test_exceptions();
        test_predictor();
        test_invalidate();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
